/* design/coreCfg_cfg.svh */
`ifndef CORECFG_CFG_SVH
`define CORECFG_CFG_SVH

// data and address width
`define XLEN 32

// architectural registers, x0 included
`define REG_COUNT 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

/* design/corePkg.sv */
`include "coreCfg_cfg.svh"

package corePkg;

    typedef logic [4:0] regName_t;

    // major opcodes the core understands
    typedef enum logic [6:0] {
        OP_REG   = 7'b0110011,
        OP_IMM   = 7'b0010011,
        OP_LUI   = 7'b0110111,
        OP_AUIPC = 7'b0010111
    } opcode_t;

    // ADD first so an all-zero word decodes to ADD
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        PASSB
    } aluOp_t;

    // A uses REG, PC or ZERO; B uses REG or IMM
    typedef enum logic [1:0] {
        REG,
        PC,
        ZERO,
        IMM
    } aluSel_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        logic [31:0]      instr;
    } fetchWord_t;

    typedef struct packed {
        logic             valid;
        logic             illegal;
        logic [`XLEN-1:0] pc;
        aluSel_t          aluSrcA;
        aluSel_t          aluSrcB;
        aluOp_t           aluOp;
        logic             regWrite;
        regName_t         rd;
        regName_t         rs1;
        regName_t         rs2;
        logic [`XLEN-1:0] read1;
        logic [`XLEN-1:0] read2;
        logic [`XLEN-1:0] imm;
    } idExWord_t;

    // also the retire port of the core
    typedef struct packed {
        logic             valid;
        logic             illegal;
        logic [`XLEN-1:0] pc;
        logic             regWrite;
        regName_t         rd;
        logic [`XLEN-1:0] result;
    } exWbWord_t;

    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [`XLEN-1:0] adr;
    } wbMaster_t;

    typedef struct packed {
        logic             ack;
        logic [`XLEN-1:0] datI;
    } wbSlave_t;

endpackage

/* design/fetchUnit.sv */
`include "coreCfg_cfg.svh"

module fetchUnit (
    input  logic                clk,
    input  logic                rstN,
    output corePkg::wbMaster_t  wbOut,
    input  corePkg::wbSlave_t   wbIn,
    output corePkg::fetchWord_t fetchOut
);

    logic [`XLEN-1:0] pc;
    logic             reqOn;
    logic             accepted;

    // a read completes when the slave acks an active request
    assign accepted = reqOn & wbIn.ack;

    // request stays up from the first cycle after reset on;
    // the pc only moves once the current read has been acked
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc    <= `RESET_PC;
            reqOn <= 1'b0;
        end else begin
            reqOn <= 1'b1;
            if (accepted) begin
                pc <= pc + `XLEN'd4;
            end
        end
    end

    // classic read cycle, cyc and stb raised together
    always_comb begin
        wbOut.cyc = reqOn;
        wbOut.stb = reqOn;
        wbOut.we  = 1'b0;
        wbOut.adr = pc;
    end

    // instruction word taken straight off the bus in the ack cycle
    always_comb begin
        fetchOut.valid = accepted;
        fetchOut.pc    = pc;
        fetchOut.instr = wbIn.datI;
    end

endmodule

/* design/decodeUnit.sv */
`include "coreCfg_cfg.svh"

module decodeUnit (
    input  corePkg::fetchWord_t fetchIn,
    output corePkg::regName_t   rs1,
    output corePkg::regName_t   rs2,
    input  logic [`XLEN-1:0]    read1,
    input  logic [`XLEN-1:0]    read2,
    output corePkg::idExWord_t  idOut
);

    import corePkg::*;

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    regName_t         rd;
    logic [`XLEN-1:0] iImm;
    logic [`XLEN-1:0] uImm;

    // funct3 to ALU op with alt selecting SUB or SRA
    function automatic aluOp_t aluFromFunct(input logic [2:0] f3, input logic alt);
        aluOp_t op;
        case (f3)
            3'b000:  op = alt ? SUB : ADD;
            3'b001:  op = SLL;
            3'b010:  op = SLT;
            3'b011:  op = SLTU;
            3'b100:  op = XOR;
            3'b101:  op = alt ? SRA : SRL;
            3'b110:  op = OR;
            default: op = AND;
        endcase
        return op;
    endfunction

    assign opcode = fetchIn.instr[6:0];
    assign rd     = fetchIn.instr[11:7];
    assign funct3 = fetchIn.instr[14:12];
    assign rs1    = fetchIn.instr[19:15];
    assign rs2    = fetchIn.instr[24:20];
    assign funct7 = fetchIn.instr[31:25];

    // sign-extended I form and U form with low 12 bits clear
    assign iImm = {{(`XLEN-12){fetchIn.instr[31]}}, fetchIn.instr[31:20]};
    assign uImm = {fetchIn.instr[31:12], 12'b0};

    always_comb begin
        // default is a bubble
        idOut = '0;
        if (fetchIn.valid) begin
            idOut.valid = 1'b1;
            idOut.pc    = fetchIn.pc;
            idOut.rd    = rd;
            idOut.rs1   = rs1;
            idOut.rs2   = rs2;
            idOut.read1 = read1;
            idOut.read2 = read2;
            case (opcode)
                OP_REG: begin
                    idOut.aluSrcA = REG;
                    idOut.aluSrcB = REG;
                    idOut.aluOp   = aluFromFunct(funct3, funct7[5]);
                    // only SUB and SRA may set funct7 bit 5
                    if (funct7 == 7'b0100000) begin
                        idOut.illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
                    end else begin
                        idOut.illegal = (funct7 != 7'b0000000);
                    end
                end
                OP_IMM: begin
                    idOut.aluSrcA = REG;
                    idOut.aluSrcB = IMM;
                    idOut.imm     = iImm;
                    idOut.aluOp   = aluFromFunct(funct3, (funct3 == 3'b101) && funct7[5]);
                    // shifts carry a 5-bit shamt and the upper bits pick the encoding
                    if (funct3 == 3'b001) begin
                        idOut.illegal = (funct7 != 7'b0000000);
                    end else if (funct3 == 3'b101) begin
                        idOut.illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                    end
                end
                OP_LUI: begin
                    idOut.aluSrcA = ZERO;
                    idOut.aluSrcB = IMM;
                    idOut.imm     = uImm;
                    idOut.aluOp   = PASSB;
                end
                OP_AUIPC: begin
                    idOut.aluSrcA = PC;
                    idOut.aluSrcB = IMM;
                    idOut.imm     = uImm;
                    idOut.aluOp   = ADD;
                end
                default: begin
                    idOut.illegal = 1'b1;
                end
            endcase
            // an illegal word retires but never writes
            idOut.regWrite = ~idOut.illegal;
        end
    end

endmodule

/* design/regFile.sv */
`include "coreCfg_cfg.svh"

module regFile (
    input  logic               clk,
    input  logic               rstN,
    input  corePkg::regName_t  rs1,
    input  corePkg::regName_t  rs2,
    output logic [`XLEN-1:0]   read1,
    output logic [`XLEN-1:0]   read2,
    input  logic               wrEn,
    input  corePkg::regName_t  rd,
    input  logic [`XLEN-1:0]   wrData
);

    logic [`XLEN-1:0] regs [`REG_COUNT];
    logic             wrLive;

    // x0 is never written
    assign wrLive = wrEn && (rd != '0);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrLive) begin
            regs[rd] <= wrData;
        end
    end

    // same-cycle write shows up on the read ports
    always_comb begin
        if (rs1 == '0) read1 = '0;
        else if (wrLive && (rd == rs1)) read1 = wrData;
        else read1 = regs[rs1];

        if (rs2 == '0) read2 = '0;
        else if (wrLive && (rd == rs2)) read2 = wrData;
        else read2 = regs[rs2];
    end

endmodule

/* design/stageReg.sv */
module stageReg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rstN,
    input  payload_t d,
    output payload_t q
);

    // all zeros form a bubble with valid and regWrite low
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

endmodule

/* design/executeUnit.sv */
`include "coreCfg_cfg.svh"

module executeUnit (
    input  corePkg::idExWord_t idIn,
    input  corePkg::exWbWord_t fwdIn,
    output corePkg::exWbWord_t exOut
);

    import corePkg::*;

    logic             fwdOk;
    logic [`XLEN-1:0] src1;
    logic [`XLEN-1:0] src2;
    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] result;

    // EX/WB entry is only a forwarding source if it actually writes
    assign fwdOk = fwdIn.regWrite && (fwdIn.rd != '0);

    assign src1 = (fwdOk && (fwdIn.rd == idIn.rs1)) ? fwdIn.result : idIn.read1;
    assign src2 = (fwdOk && (fwdIn.rd == idIn.rs2)) ? fwdIn.result : idIn.read2;

    always_comb begin
        case (idIn.aluSrcA)
            PC:      opA = idIn.pc;
            ZERO:    opA = '0;
            default: opA = src1;
        endcase
    end

    assign opB   = (idIn.aluSrcB == IMM) ? idIn.imm : src2;
    assign shamt = opB[4:0];

    always_comb begin
        case (idIn.aluOp)
            SUB:     result = opA - opB;
            AND:     result = opA & opB;
            OR:      result = opA | opB;
            XOR:     result = opA ^ opB;
            SLT:     result = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            SLTU:    result = {{(`XLEN-1){1'b0}}, opA < opB};
            SLL:     result = opA << shamt;
            SRL:     result = opA >> shamt;
            SRA:     result = $unsigned($signed(opA) >>> shamt);
            PASSB:   result = opB;
            default: result = opA + opB;
        endcase
    end

    always_comb begin
        exOut.valid    = idIn.valid;
        exOut.illegal  = idIn.illegal;
        exOut.pc       = idIn.pc;
        exOut.regWrite = idIn.regWrite;
        exOut.rd       = idIn.rd;
        exOut.result   = result;
    end

endmodule

/* design/pipeCore.sv */
`include "coreCfg_cfg.svh"

module pipeCore (
    input  logic               clk,
    input  logic               rstN,
    output corePkg::wbMaster_t wbOut,
    input  corePkg::wbSlave_t  wbIn,
    output corePkg::exWbWord_t retire
);

    import corePkg::*;

    fetchWord_t       fetchWord;
    regName_t         rs1;
    regName_t         rs2;
    logic [`XLEN-1:0] read1;
    logic [`XLEN-1:0] read2;
    idExWord_t        idWord;
    idExWord_t        idExQ;
    exWbWord_t        exWord;

    fetchUnit fetch (
        .clk      (clk),
        .rstN     (rstN),
        .wbOut    (wbOut),
        .wbIn     (wbIn),
        .fetchOut (fetchWord)
    );

    decodeUnit decode (
        .fetchIn (fetchWord),
        .rs1     (rs1),
        .rs2     (rs2),
        .read1   (read1),
        .read2   (read2),
        .idOut   (idWord)
    );

    // writeback comes straight from the retire entry
    regFile regs (
        .clk    (clk),
        .rstN   (rstN),
        .rs1    (rs1),
        .rs2    (rs2),
        .read1  (read1),
        .read2  (read2),
        .wrEn   (retire.regWrite),
        .rd     (retire.rd),
        .wrData (retire.result)
    );

    stageReg #(.payload_t(idExWord_t)) idExReg (
        .clk  (clk),
        .rstN (rstN),
        .d    (idWord),
        .q    (idExQ)
    );

    executeUnit execute (
        .idIn  (idExQ),
        .fwdIn (retire),
        .exOut (exWord)
    );

    stageReg #(.payload_t(exWbWord_t)) exWbReg (
        .clk  (clk),
        .rstN (rstN),
        .d    (exWord),
        .q    (retire)
    );

endmodule

/* sim/pipeCore_chk.sv */
module pipeCore_chk (
    input logic               clk,
    input logic               rstN,
    input corePkg::wbMaster_t wbOut,
    input corePkg::wbSlave_t  wbIn,
    input corePkg::exWbWord_t retire
);

    // strobe only inside a cycle
    stbInCyc: assert property (@(posedge clk) disable iff (!rstN)
        wbOut.stb |-> wbOut.cyc)
        else $error("stb raised without cyc");

    // request and address held until the slave acks
    holdUntilAck: assert property (@(posedge clk) disable iff (!rstN)
        (wbOut.stb && !wbIn.ack) |=> (wbOut.stb && $stable(wbOut.adr)))
        else $error("request dropped or address moved before ack");

    // two stage registers between ack and retire
    ackToRetire: assert property (@(posedge clk) disable iff (!rstN)
        (wbOut.stb && wbIn.ack) |-> ##2 retire.valid)
        else $error("acked read did not retire two cycles later");

    retireFromAck: assert property (@(posedge clk) disable iff (!rstN)
        retire.valid |-> $past(wbOut.stb && wbIn.ack, 2))
        else $error("retire without an ack two cycles before");

    noRetireInReset: assert property (@(posedge clk)
        !rstN |-> !retire.valid)
        else $error("retire valid during reset");

endmodule

bind pipeCore pipeCore_chk chk (.*);

/* sim/pipeCoreTb.sv */
`include "coreCfg_cfg.svh"

module pipeCoreTb;

    import corePkg::*;

    localparam int ProgLen = 64;
    localparam int CycleLimit = ProgLen * 6 + 200;

    logic        clk = 1'b0;
    logic        rstN = 1'b0;
    wbMaster_t   wbOut;
    wbSlave_t    wbIn;
    exWbWord_t   retire;
    logic [31:0] prog [ProgLen];
    logic [31:0] modelRegs [32];
    exWbWord_t   expQ [$];
    int          tagQ [$];
    int          checks [6];
    int          errs [6];
    int          fetchCount = 0;
    int          retireCount = 0;
    int          waitLeft = 0;
    int          cycles = 0;
    logic [31:0] nextAdr;
    logic [31:0] lastPc;
    logic        afterReset = 1'b0;

    pipeCore i_dut (
        .clk    (clk),
        .rstN   (rstN),
        .wbOut  (wbOut),
        .wbIn   (wbIn),
        .retire (retire)
    );

    always #4 clk = ~clk;

    task automatic checkField(int test, string name, logic [31:0] got, logic [31:0] exp);
        checks[test]++;
        assert (got === exp) else begin
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            errs[test]++;
        end
    endtask

    // reference ALU from the RV32I rules
    function automatic logic [31:0] aluModel(logic [2:0] f3, logic alt, logic [31:0] a,
                                             logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // words 16 to 31 form a chain where each reads the previous rd
    function automatic logic [31:0] randomInstr(int idx, logic [4:0] prevRd);
        int          kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        kind = $urandom % 10;
        rd = 5'($urandom % 8);
        rs1 = 5'($urandom % 8);
        rs2 = 5'($urandom % 8);
        f3 = 3'($urandom);
        f7 = 7'h00;
        imm = 12'($urandom);
        if (idx >= 16 && idx < 32) rs1 = prevRd;
        case (kind)
            0: return {imm, rs1, f3, rd, 7'b1110011};
            1: return {imm, rs1, f3, rd, 7'b0110111};
            2: return {imm, rs1, f3, rd, 7'b0010111};
            3, 4, 5: begin
                if ((f3 == 3'd0 || f3 == 3'd5) && ($urandom % 2 == 1)) begin
                    f7 = 7'h20;
                end else if ($urandom % 16 == 0) begin
                    // funct7 outside the base ISA
                    f7 = 7'h01;
                end
                return {f7, rs2, rs1, f3, rd, 7'b0110011};
            end
            default: begin
                if (f3 == 3'd1) imm[11:5] = 7'h00;
                else if (f3 == 3'd5) imm[11:5] = ($urandom % 2 == 1) ? 7'h20 : 7'h00;
                return {imm, rs1, f3, rd, 7'b0010011};
            end
        endcase
    endfunction

    // executes one fetched word in order and queues its retire entry
    task automatic runModel(logic [31:0] ins, logic [31:0] pc, int idx);
        exWbWord_t   e;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [2:0]  f3;
        logic [6:0]  f7;
        f3 = ins[14:12];
        f7 = ins[31:25];
        a = modelRegs[ins[19:15]];
        b = modelRegs[ins[24:20]];
        immI = {{20{ins[31]}}, ins[31:20]};
        e = '0;
        e.valid = 1'b1;
        e.pc = pc;
        e.rd = ins[11:7];
        case (ins[6:0])
            7'b0110011: begin
                e.illegal = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
                e.result = aluModel(f3, f7[5], a, b);
            end
            7'b0010011: begin
                e.illegal = (f3 == 3'd1 && f7 != 7'h00) ||
                            (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
                e.result = aluModel(f3, f3 == 3'd5 && f7[5], a, immI);
            end
            7'b0110111: e.result = {ins[31:12], 12'b0};
            7'b0010111: e.result = pc + {ins[31:12], 12'b0};
            default: e.illegal = 1'b1;
        endcase
        e.regWrite = !e.illegal;
        if (e.regWrite && e.rd != 5'd0) modelRegs[e.rd] = e.result;
        expQ.push_back(e);
        if (e.illegal || e.rd == 5'd0) tagQ.push_back(4);
        else if (idx >= 16 && idx < 32) tagQ.push_back(3);
        else tagQ.push_back(2);
    endtask

    // Wishbone slave whose chain region answers with no wait states
    always @(posedge clk) begin
        int w;
        if (!rstN) begin
            wbIn <= '0;
        end else if (wbOut.stb && fetchCount < ProgLen) begin
            if (wbIn.ack) begin
                checkField((fetchCount == 0) ? 1 : 5, "wbOut.adr", wbOut.adr, nextAdr);
                checkField(5, "wbOut.we", 32'(wbOut.we), 32'd0);
                runModel(wbIn.datI, nextAdr, fetchCount);
                nextAdr += 4;
                fetchCount++;
                w = (fetchCount >= 16 && fetchCount < 32) ? 0 : int'($urandom % 4);
                if (w == 0 && fetchCount < ProgLen) begin
                    wbIn.ack <= 1'b1;
                    wbIn.datI <= prog[fetchCount];
                end else begin
                    wbIn.ack <= 1'b0;
                    waitLeft = (w > 0) ? w - 1 : 0;
                end
            end else if (waitLeft == 0) begin
                wbIn.ack <= 1'b1;
                wbIn.datI <= prog[fetchCount];
            end else begin
                waitLeft--;
            end
        end else begin
            wbIn.ack <= 1'b0;
        end
    end

    // retire monitor
    always @(posedge clk) begin
        exWbWord_t e;
        int        t;
        if (!rstN || !afterReset) begin
            afterReset = rstN;
            checkField(1, "wbOut.cyc", 32'(wbOut.cyc), 32'd0);
            checkField(1, "wbOut.stb", 32'(wbOut.stb), 32'd0);
            checkField(1, "retire.valid", 32'(retire.valid), 32'd0);
        end else if (retire.valid) begin
            assert (expQ.size() > 0) else begin
                $display("Retire at %0t with no instruction outstanding", $time);
                errs[5]++;
            end
            if (expQ.size() > 0) begin
                e = expQ.pop_front();
                t = tagQ.pop_front();
                checkField(t, "retire.illegal", 32'(retire.illegal), 32'(e.illegal));
                checkField(t, "retire.pc", retire.pc, e.pc);
                checkField(t, "retire.regWrite", 32'(retire.regWrite), 32'(e.regWrite));
                if (e.regWrite) begin
                    checkField(t, "retire.rd", 32'(retire.rd), 32'(e.rd));
                    checkField(t, "retire.result", retire.result, e.result);
                end
            end
            if (retireCount > 0) checkField(5, "retire.pc step", retire.pc, lastPc + 4);
            lastPc = retire.pc;
            retireCount++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CycleLimit) begin
            $display("Timeout after %0d cycles with %0d of %0d retired",
                     cycles, retireCount, ProgLen);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        string    names [6];
        int       total;
        int       failed;
        logic [4:0] prevRd;
        names = '{"", "reset", "ALU results", "back-to-back dependencies",
                  "x0 and illegal words", "ordering and address"};
        void'($urandom(32'haa00));
        wbIn = '0;
        prevRd = 5'd0;
        for (int i = 0; i < 32; i++) modelRegs[i] = '0;
        for (int i = 0; i < ProgLen; i++) begin
            prog[i] = randomInstr(i, prevRd);
            prevRd = prog[i][11:7];
        end
        waitLeft = $urandom % 3;
        nextAdr = `RESET_PC;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
        wait (fetchCount > 0);
        @(posedge clk);
        $display("test 1 %s: %0d checks, %0d errors", names[1], checks[1], errs[1]);
        wait (retireCount == ProgLen);
        repeat (3) @(posedge clk);
        assert (expQ.size() == 0) else begin
            $display("%0d expected retires never arrived", expQ.size());
            errs[5]++;
        end
        total = 0;
        failed = 0;
        for (int k = 2; k <= 5; k++) begin
            $display("test %0d %s: %0d checks, %0d errors", k, names[k], checks[k], errs[k]);
        end
        for (int k = 1; k <= 5; k++) begin
            total += checks[k];
            failed += errs[k];
        end
        $display("total: %0d checks, %0d errors", total, failed);
        if (failed == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* pipeCore.f */
+incdir+design
design/corePkg.sv
design/fetchUnit.sv
design/decodeUnit.sv
design/regFile.sv
design/stageReg.sv
design/executeUnit.sv
design/pipeCore.sv
sim/pipeCore_chk.sv
sim/pipeCoreTb.sv

/* run.sh */
#!/bin/sh
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f pipeCore.f --top-module pipeCoreTb -o simPipeCore

./obj_dir/simPipeCore | tee sim.log

if grep -q "All checks passed" sim.log; then
    exit 0
fi
exit 1
